/* rtl/axi_lite_pkg.sv */
package axi_lite_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    // read response codes, same encoding as the AXI spec
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // AR channel payload, master to slave
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [2:0]            prot;
    } axi_ar_t;

    // R channel payload, slave to master
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        axi_resp_e             resp;
    } axi_r_t;

endpackage

/* rtl/fetch_pkg.sv */
package fetch_pkg;

    localparam int XLEN        = 32;
    localparam int INST_LEN    = 32;
    localparam int QUEUE_DEPTH = 2;

    // queue pointer and occupancy widths
    localparam int QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // one fetched word as handed to decode
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [INST_LEN-1:0] instr;
        logic                fault;   // response was not OKAY
    } fetch_entry_t;

    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_ADDR = 2'd1,   // ar_valid up, waiting for ar_ready
        FETCH_DATA = 2'd2    // r_ready up, waiting for r_valid
    } fetch_state_e;

endpackage

/* rtl/pc_gen.sv */
module pc_gen
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            advance_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_d;

    always_comb begin
        pc_d = pc_q;
        if (redirect_i) begin
            pc_d = redirect_pc_i;        // redirect beats advance
        end else if (advance_i) begin
            pc_d = pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // only word fetches, no compressed instructions
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00
    ) else $error("pc_gen: misaligned pc %h", pc_o);

endmodule

/* rtl/fetch_fsm.sv */
module fetch_fsm
    import axi_lite_pkg::*;
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            redirect_i,
    input  logic            full_i,
    // AR channel
    output logic            ar_valid_o,
    output axi_ar_t         ar_o,
    input  logic            ar_ready_i,
    // R channel
    input  logic            r_valid_i,
    input  axi_r_t          r_i,
    output logic            r_ready_o,
    // to pc_gen and queue
    output logic            advance_o,
    output logic            push_o,
    output fetch_entry_t    entry_o
);

    // instruction access, unprivileged, secure
    localparam logic [2:0] AR_PROT = 3'b100;

    fetch_state_e    state_q;
    fetch_state_e    state_d;
    logic [XLEN-1:0] req_pc_q;
    logic            killed_q;
    logic            ar_fire;
    logic            r_fire;

    assign ar_valid_o = (state_q == FETCH_ADDR);
    assign r_ready_o  = (state_q == FETCH_DATA);
    assign ar_fire    = ar_valid_o && ar_ready_i;
    assign r_fire     = r_valid_i && r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                // hold off one cycle on redirect so pc_i carries the target
                if (!full_i && !redirect_i) begin
                    state_d = FETCH_ADDR;
                end
            end
            FETCH_ADDR: begin
                if (ar_fire) begin
                    state_d = FETCH_DATA;
                end
            end
            FETCH_DATA: begin
                if (r_fire) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= FETCH_IDLE;
            killed_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == FETCH_IDLE || r_fire) begin
                killed_q <= 1'b0;
            end else if (redirect_i) begin
                killed_q <= 1'b1;        // read stays on the bus, data gets dropped
            end
        end
    end

    // request address, held until the AR transfer
    always_ff @(posedge clk) begin
        if (state_q == FETCH_IDLE && state_d == FETCH_ADDR) begin
            req_pc_q <= pc_i;
        end
    end

    assign ar_o.addr = req_pc_q;
    assign ar_o.prot = AR_PROT;

    // a killed read must not step the freshly loaded pc
    assign advance_o = ar_fire && !killed_q && !redirect_i;
    assign push_o    = r_fire && !killed_q && !redirect_i;

    assign entry_o.pc    = req_pc_q;
    assign entry_o.instr = r_i.data;
    assign entry_o.fault = (r_i.resp != RESP_OKAY);

    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o.addr)
    ) else $error("fetch_fsm: AR dropped or changed before transfer");

    // launch gating on full_i plus a single outstanding read
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        push_o |-> !full_i
    ) else $error("fetch_fsm: push into full queue");

endmodule

/* rtl/inst_queue.sv */
module inst_queue
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         push_i,
    input  fetch_entry_t entry_i,
    input  logic         pop_ready_i,
    output logic         full_o,
    output logic         valid_o,
    output fetch_entry_t entry_o
);

    fetch_entry_t      mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QCNT_W-1:0] count_q;
    logic              pop;

    function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] ptr);
        logic [QPTR_W-1:0] nxt;
        nxt = (ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign valid_o = (count_q != '0);
    assign full_o  = (count_q == QCNT_W'(QUEUE_DEPTH));
    assign entry_o = mem[rd_ptr_q];
    assign pop     = valid_o && pop_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= entry_i;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        count_q <= QCNT_W'(QUEUE_DEPTH)
    ) else $error("inst_queue: count %0d over depth", count_q);

endmodule

/* rtl/fetch_top.sv */
module fetch_top
    import axi_lite_pkg::*;
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    // AXI4-Lite read port
    output logic            ar_valid_o,
    output axi_ar_t         ar_o,
    input  logic            ar_ready_i,
    input  logic            r_valid_i,
    input  axi_r_t          r_i,
    output logic            r_ready_o,
    // decode side
    output logic            inst_valid_o,
    output fetch_entry_t    inst_o,
    input  logic            inst_ready_i
);

    logic [XLEN-1:0] pc;
    logic            advance;
    logic            push;
    logic            queue_full;
    fetch_entry_t    fetch_entry;

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .advance_i     (advance),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .pc_o          (pc)
    );

    fetch_fsm u_fetch_fsm (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pc_i       (pc),
        .redirect_i (redirect_i),
        .full_i     (queue_full),
        .ar_valid_o (ar_valid_o),
        .ar_o       (ar_o),
        .ar_ready_i (ar_ready_i),
        .r_valid_i  (r_valid_i),
        .r_i        (r_i),
        .r_ready_o  (r_ready_o),
        .advance_o  (advance),
        .push_o     (push),
        .entry_o    (fetch_entry)
    );

    inst_queue u_inst_queue (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (redirect_i),      // redirect drops everything queued
        .push_i      (push),
        .entry_i     (fetch_entry),
        .pop_ready_i (inst_ready_i),
        .full_o      (queue_full),
        .valid_o     (inst_valid_o),
        .entry_o     (inst_o)
    );

endmodule

/* verification/axi_lite_mem_model.sv */
module axi_lite_mem_model
    import axi_lite_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    ar_valid_i,
    input  axi_ar_t ar_i,
    output logic    ar_ready_o,
    output logic    r_valid_o,
    output axi_r_t  r_o,
    input  logic    r_ready_i
);

    localparam logic [AXI_DATA_W-1:0] DATA_KEY = 32'h5a3c_96e1;
    localparam logic [AXI_ADDR_W-1:0] ERR_BASE = 32'h9000_0000;

    logic                  busy;      // one read accepted, response pending
    logic [1:0]            ar_wait;
    logic [1:0]            r_wait;
    logic [AXI_ADDR_W-1:0] addr_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy       <= 1'b0;
            ar_wait    <= '0;
            r_wait     <= '0;
            addr_q     <= '0;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
        end else begin
            ar_ready_o <= 1'b0;             // ready is a one cycle pulse
            if (!busy) begin
                if (ar_valid_i && ar_ready_o) begin
                    busy    <= 1'b1;
                    addr_q  <= ar_i.addr;
                    r_wait  <= 2'($urandom_range(3, 0));
                    ar_wait <= 2'($urandom_range(3, 0));
                end else if (ar_valid_i) begin
                    if (ar_wait == '0) begin
                        ar_ready_o <= 1'b1;
                    end else begin
                        ar_wait <= ar_wait - 1'b1;
                    end
                end
            end else if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                busy      <= 1'b0;
            end else if (!r_valid_o) begin
                if (r_wait == '0) begin
                    r_valid_o <= 1'b1;
                    if (addr_q >= ERR_BASE) begin
                        r_o.data <= '0;
                        r_o.resp <= RESP_SLVERR;
                    end else begin
                        r_o.data <= {addr_q[24:0], addr_q[31:25]} ^ DATA_KEY;
                        r_o.resp <= RESP_OKAY;
                    end
                end else begin
                    r_wait <= r_wait - 1'b1;
                end
            end
        end
    end

endmodule

/* verification/tb_fetch_top.sv */
module tb_fetch_top
    import axi_lite_pkg::*;
    import fetch_pkg::*;
();

    localparam logic [31:0] DATA_KEY   = 32'h5a3c_96e1;
    localparam logic [31:0] ERR_BASE   = 32'h9000_0000;
    localparam logic [2:0]  EXP_PROT   = 3'b100;   // instruction, unprivileged, secure
    localparam int          MAX_CYCLES = 6000;   // ~400 fetches at 8 cycles plus margin
    localparam logic [1:0]  READY_LOW  = 2'd0;
    localparam logic [1:0]  READY_HIGH = 2'd1;
    localparam logic [1:0]  READY_RAND = 2'd2;

    logic            clk;
    logic            rst_n_i;
    logic            redirect_i;
    logic [XLEN-1:0] redirect_pc_i;
    logic            ar_valid;
    axi_ar_t         ar;
    logic            ar_ready;
    logic            r_valid;
    axi_r_t          r;
    logic            r_ready;
    logic            inst_valid_o;
    fetch_entry_t    inst_o;
    logic            inst_ready_i;

    logic [1:0]      ready_mode;
    string           test_name;
    logic [XLEN-1:0] exp_pc;
    int              hs_count;
    int              err_cnt;
    int              check_cnt;
    int              cycle_cnt;

    fetch_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .ar_valid_o    (ar_valid),
        .ar_o          (ar),
        .ar_ready_i    (ar_ready),
        .r_valid_i     (r_valid),
        .r_i           (r),
        .r_ready_o     (r_ready),
        .inst_valid_o  (inst_valid_o),
        .inst_o        (inst_o),
        .inst_ready_i  (inst_ready_i)
    );

    axi_lite_mem_model u_mem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready)
    );

    always #5 clk = ~clk;

    // expected entry for a fetch address
    function automatic fetch_entry_t exp_entry(input logic [XLEN-1:0] pc);
        fetch_entry_t e;
        e.pc = pc;
        if (pc >= ERR_BASE) begin
            e.instr = '0;
            e.fault = 1'b1;
        end else begin
            e.instr = {pc[24:0], pc[31:25]} ^ DATA_KEY;   // rotl 7
            e.fault = 1'b0;
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("[FAIL] %s: expected %h, actual %h (t=%0t)", name, expected, actual, $time);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, checks: %0d, entries: %0d", err_cnt, check_cnt, hs_count);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // waits for n more decode handshakes
    task automatic deliver(input int n);
        int target;
        target = hs_count + n;
        while (hs_count < target) @(posedge clk);
    endtask

    task automatic redirect_to(input logic [XLEN-1:0] target);
        redirect_i    <= 1'b1;
        redirect_pc_i <= target;
        @(posedge clk);
        redirect_i    <= 1'b0;
    endtask

    always @(posedge clk) begin
        case (ready_mode)
            READY_LOW:  inst_ready_i <= 1'b0;
            READY_HIGH: inst_ready_i <= 1'b1;
            default:    inst_ready_i <= 1'($urandom_range(1, 0));
        endcase
    end

    // entry checked before a redirect moves the expected pc
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (ar_valid && ar_ready) begin
                check_value("ar_prot", EXP_PROT, ar.prot);
            end
            if (inst_valid_o && inst_ready_i) begin
                check_value(test_name, exp_entry(exp_pc), inst_o);
                exp_pc = exp_pc + 32'd4;
                hs_count <= hs_count + 1;
            end
            if (redirect_i) begin
                exp_pc = redirect_pc_i;
            end
        end
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        err_cnt++;
        finish_run();
    end

    initial begin
        logic [XLEN-1:0] target;
        void'($urandom(61283));
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        inst_ready_i  = 1'b0;
        ready_mode    = READY_HIGH;
        test_name     = "reset";
        exp_pc        = RESET_PC;
        hs_count      = 0;
        err_cnt       = 0;
        check_cnt     = 0;
        cycle_cnt     = 0;
        repeat (2) @(posedge clk);
        check_value("reset_inst_valid", 0, inst_valid_o);
        check_value("reset_ar_valid", 0, ar_valid);
        check_value("reset_r_ready", 0, r_ready);
        rst_n_i <= 1'b1;
        deliver(1);

        test_name <= "stream";
        deliver(100);

        test_name  <= "backpressure";
        ready_mode <= READY_RAND;
        deliver(100);
        ready_mode <= READY_LOW;
        repeat (40) @(posedge clk);         // queue fills and fetch parks in idle
        repeat (20) begin
            @(posedge clk);
            check_value("hold_full_ar_valid", 0, ar_valid);
            check_value("hold_full_inst_valid", 1, inst_valid_o);
        end
        ready_mode <= READY_RAND;
        deliver(20);

        test_name <= "redirect";
        for (int i = 0; i < 20; i++) begin
            deliver($urandom_range(5, 0));
            if (i % 2 == 0) begin
                while (!(ar_valid || r_ready)) @(posedge clk);   // read in flight
            end
            target = {4'h8, 26'($urandom), 2'b00};
            redirect_to(target);
        end
        deliver(4);

        test_name  <= "error_region";
        ready_mode <= READY_HIGH;
        redirect_to(32'h9000_0100);
        deliver(10);
        test_name <= "error_recover";
        redirect_to(32'h8000_2000);
        deliver(10);

        finish_run();
    end

endmodule

/* sim.f */
rtl/axi_lite_pkg.sv
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/fetch_fsm.sv
rtl/inst_queue.sv
rtl/fetch_top.sv
verification/axi_lite_mem_model.sv
verification/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - rtl/axi_lite_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/pc_gen.sv
      - rtl/fetch_fsm.sv
      - rtl/inst_queue.sv
      - rtl/fetch_top.sv
  - target: simulation
    files:
      - verification/axi_lite_mem_model.sv
      - verification/tb_fetch_top.sv
